// File: agc_loop_pkg.sv
package agc_loop_pkg;

    // Seven AGC information words in the order status, sum of squares, above,
    // below, scale, offset and channel mask
    typedef logic [6:0][31:0] agc_info_t;

    // Starting values and limits
    localparam logic [16:0]        START_SCALE        = 17'd1500;
    localparam logic signed [15:0] START_OFFSET       = 16'sd0;
    localparam logic [16:0]        START_SCALE_DELTA  = 17'd30;
    localparam logic [15:0]        START_OFFSET_DELTA = 16'd25;
    localparam int unsigned        TARGET_RMS_SQUARED = 16;
    localparam int unsigned        RMS_SQUARE_ERR     = 0;
    localparam int unsigned        OFFSET_ERR         = 5;
    localparam logic [16:0]        SCALE_MIN          = 17'd300;
    localparam logic [16:0]        SCALE_MAX          = 17'd130000;
    localparam int unsigned        TIMESCALE_SHIFT    = 17 - 4;   // 4 reduction bits
    localparam int unsigned        BOOT_DELAY         = 31;
    localparam int unsigned        BOOT_CNT_W         = $clog2(BOOT_DELAY + 1);
    localparam int unsigned        INFO_WORDS         = 6;

    // Downstream AGC map
    localparam logic [7:0] ADDR_CTRL       = 8'h00;
    localparam logic [7:0] ADDR_SCALE      = 8'h10;
    localparam logic [7:0] ADDR_OFFSET     = 8'h14;
    localparam int unsigned STATUS_DONE_BIT = 1;

    typedef enum logic [31:0] {
        CMD_START = 32'h0000_0001,
        CMD_RESET = 32'h0000_0004,
        CMD_LOAD  = 32'h0000_0300,
        CMD_APPLY = 32'h0000_0400
    } agc_cmd_e;

    // Host map decoded on bits 6:2
    localparam logic [7:0] HOST_MASK_ADDR   = 8'h18;
    localparam logic [7:0] HOST_SDELTA_ADDR = 8'h40;
    localparam logic [7:0] HOST_ODELTA_ADDR = 8'h44;

    typedef enum logic [3:0] {
        LOOP_BOOT, LOOP_WRITE_SCALE, LOOP_WRITE_OFFSET, LOOP_LOAD, LOOP_APPLY,
        LOOP_RESET, LOOP_START, LOOP_POLL, LOOP_READ, LOOP_CALC
    } loop_state_e;

    typedef enum logic [1:0] {HOST_IDLE, HOST_WRITE, HOST_READ, HOST_ACK} host_state_e;

    typedef enum logic {BUS_IDLE, BUS_WAIT} bus_state_e;

endpackage

// File: agc_host_regs.sv
`timescale 1ns/1ps

module agc_host_regs
    import agc_loop_pkg::*;
(
    input  logic        aclk,
    input  logic        wb_rst_i,
    input  logic        host_cyc_i,
    input  logic        host_stb_i,
    input  logic        host_we_i,
    input  logic [7:0]  host_adr_i,
    input  logic [31:0] host_dat_i,
    input  agc_info_t   agc_info_i,
    output logic        host_ack_o,
    output logic [31:0] host_dat_o,
    output logic [16:0] scale_delta_o,
    output logic [15:0] offset_delta_o,
    output logic        chan_mask_o
);

    host_state_e state;

    assign host_ack_o = (state == HOST_ACK);

    ////////////////////////////////////////
    // Acknowledge FSM and register writes
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state          <= HOST_IDLE;
            scale_delta_o  <= START_SCALE_DELTA;
            offset_delta_o <= START_OFFSET_DELTA;
            chan_mask_o    <= 1'b0;
        end else begin
            case (state)
                HOST_IDLE: begin
                    if (host_cyc_i && host_stb_i) begin
                        state <= host_we_i ? HOST_WRITE : HOST_READ;
                    end
                end
                HOST_WRITE: state <= HOST_ACK;
                HOST_READ:  state <= HOST_ACK;
                default:    state <= HOST_IDLE;   // ACK lasts one cycle
            endcase

            if (state == HOST_WRITE) begin
                if (host_adr_i[6:2] == HOST_MASK_ADDR[6:2])
                    chan_mask_o <= host_dat_i[0];
                if (host_adr_i[6:2] == HOST_SDELTA_ADDR[6:2])
                    scale_delta_o <= host_dat_i[16:0];
                if (host_adr_i[6:2] == HOST_ODELTA_ADDR[6:2])
                    offset_delta_o <= host_dat_i[15:0];
            end
        end
    end

    // Read response is held until the next read
    always_ff @(posedge aclk) begin
        if (state == HOST_READ) begin
            if (host_adr_i[6]) begin   // Loop step registers
                case (host_adr_i[5:2])
                    4'd0:    host_dat_o <= {15'd0, scale_delta_o};
                    4'd1:    host_dat_o <= {{16{offset_delta_o[15]}}, offset_delta_o};
                    default: host_dat_o <= 32'd0;
                endcase
            end else if (host_adr_i[5:2] <= 4'd6) begin
                host_dat_o <= agc_info_i[host_adr_i[5:2]];   // Information word
            end else begin
                host_dat_o <= 32'd0;
            end
        end
    end

endmodule

// File: agc_bus_master.sv
`timescale 1ns/1ps

module agc_bus_master
    import agc_loop_pkg::*;
(
    input  logic        aclk,
    input  logic        wb_rst_i,
    input  logic        req_i,
    input  logic        we_i,
    input  logic [7:0]  adr_i,
    input  logic [31:0] wdat_i,
    output logic        done_o,
    output logic [31:0] rdat_o,
    output logic        agc_cyc_o,
    output logic        agc_stb_o,
    output logic        agc_we_o,
    output logic [7:0]  agc_adr_o,
    output logic [31:0] agc_dat_o,
    output logic [3:0]  agc_sel_o,
    input  logic        agc_ack_i,
    input  logic [31:0] agc_dat_i
);

    bus_state_e state;

    // Cycle is open for the whole wait
    assign agc_cyc_o = (state == BUS_WAIT);
    assign agc_stb_o = agc_cyc_o;
    assign agc_sel_o = {4{agc_cyc_o}};

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state    <= BUS_IDLE;
            agc_we_o <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                BUS_IDLE: begin
                    if (req_i) begin
                        state    <= BUS_WAIT;
                        agc_we_o <= we_i;
                    end
                end
                default: begin
                    if (agc_ack_i) begin
                        state    <= BUS_IDLE;
                        agc_we_o <= 1'b0;
                        done_o   <= 1'b1;   // One cycle after the ack
                    end
                end
            endcase
        end
    end

    // Address and write data of the request, read data of the ack
    always_ff @(posedge aclk) begin
        if (state == BUS_IDLE && req_i) begin
            agc_adr_o <= adr_i;
            agc_dat_o <= wdat_i;
        end
        if (state == BUS_WAIT && agc_ack_i && !agc_we_o)
            rdat_o <= agc_dat_i;
    end

endmodule

// File: agc_update_calc.sv
`timescale 1ns/1ps

module agc_update_calc
    import agc_loop_pkg::*;
(
    input  agc_info_t   agc_info_i,
    input  logic [16:0] scale_delta_i,
    input  logic [15:0] offset_delta_i,
    input  logic [16:0] prev_scale_i,
    input  logic [15:0] prev_offset_i,
    output logic [16:0] next_scale_o,
    output logic [15:0] next_offset_o
);

    logic [31:0] sq_adj;
    logic [16:0] scale_cur;
    logic [15:0] offset_cur;
    logic [32:0] above;
    logic [32:0] below;

    assign sq_adj     = agc_info_i[1] >> TIMESCALE_SHIFT;   // Reduced sum of squares
    assign scale_cur  = agc_info_i[4][16:0];
    assign offset_cur = agc_info_i[5][15:0];
    assign above      = {1'b0, agc_info_i[2]};
    assign below      = {1'b0, agc_info_i[3]};

    // Scale steps toward the target band within the cutoffs
    always_comb begin
        next_scale_o = prev_scale_i;
        if (sq_adj > 32'(TARGET_RMS_SQUARED + RMS_SQUARE_ERR))
            next_scale_o = (scale_cur > SCALE_MIN) ? scale_cur - scale_delta_i : scale_cur;
        else if (sq_adj < 32'(TARGET_RMS_SQUARED - RMS_SQUARE_ERR))
            next_scale_o = (scale_cur < SCALE_MAX) ? scale_cur + scale_delta_i : scale_cur;
    end

    // Offset balances the above and below counts
    always_comb begin
        next_offset_o = prev_offset_i;
        if (above > below + 33'(OFFSET_ERR))
            next_offset_o = offset_cur - offset_delta_i;
        else if (below > above + 33'(OFFSET_ERR))
            next_offset_o = offset_cur + offset_delta_i;
    end

endmodule

// File: agc_loop_fsm.sv
`timescale 1ns/1ps

module agc_loop_fsm
    import agc_loop_pkg::*;
(
    input  logic        aclk,
    input  logic        wb_rst_i,
    input  logic        agc_reset_i,
    input  logic        bus_done_i,
    input  logic [31:0] bus_rdat_i,
    output logic        bus_req_o,
    output logic        bus_we_o,
    output logic [7:0]  bus_adr_o,
    output logic [31:0] bus_wdat_o,
    input  logic        chan_mask_i,
    input  logic [16:0] next_scale_i,
    input  logic [15:0] next_offset_i,
    output logic [16:0] cur_scale_o,
    output logic [15:0] cur_offset_o,
    output agc_info_t   agc_info_o
);

    loop_state_e           state;
    logic [BOOT_CNT_W-1:0] boot_cnt;
    logic [2:0]            info_idx;   // Word being read

    ////////////////////////////////////////
    // Loop sequencer
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            state        <= LOOP_BOOT;
            boot_cnt     <= BOOT_CNT_W'(BOOT_DELAY);
            info_idx     <= 3'd0;
            bus_req_o    <= 1'b0;
            cur_scale_o  <= START_SCALE;
            cur_offset_o <= START_OFFSET;
        end else begin
            bus_req_o <= 1'b0;
            case (state)
                LOOP_BOOT: begin
                    if (boot_cnt != '0) begin
                        boot_cnt <= boot_cnt - 1'b1;
                    end else begin
                        state     <= LOOP_WRITE_SCALE;
                        bus_req_o <= 1'b1;
                    end
                end
                LOOP_CALC: begin   // Single cycle, no bus access
                    cur_scale_o  <= next_scale_i;
                    cur_offset_o <= next_offset_i;
                    state        <= LOOP_WRITE_SCALE;
                    bus_req_o    <= 1'b1;
                end
                default: begin
                    if (bus_done_i) begin
                        bus_req_o <= 1'b1;
                        case (state)
                            LOOP_WRITE_SCALE:  state <= LOOP_WRITE_OFFSET;
                            LOOP_WRITE_OFFSET: state <= LOOP_LOAD;
                            LOOP_LOAD:         state <= LOOP_APPLY;
                            LOOP_APPLY:        state <= LOOP_RESET;
                            LOOP_RESET:        state <= LOOP_START;
                            LOOP_START:        state <= LOOP_POLL;
                            LOOP_POLL: begin
                                if (bus_rdat_i[STATUS_DONE_BIT]) begin
                                    state    <= LOOP_READ;
                                    info_idx <= 3'd0;
                                end   // else poll again
                            end
                            default: begin   // READ
                                if (info_idx == 3'(INFO_WORDS - 1)) begin
                                    state     <= LOOP_CALC;
                                    bus_req_o <= 1'b0;
                                end else begin
                                    info_idx <= info_idx + 1'b1;
                                end
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    // Information store
    always_ff @(posedge aclk) begin
        if (state == LOOP_READ && bus_done_i)
            agc_info_o[info_idx] <= bus_rdat_i;
        if (state == LOOP_APPLY && bus_done_i) begin   // Applied values become visible
            agc_info_o[4] <= {15'd0, cur_scale_o};
            agc_info_o[5] <= {{16{cur_offset_o[15]}}, cur_offset_o};
            agc_info_o[6] <= {31'd0, chan_mask_i};
        end
    end

    // Request fields follow the state
    always_comb begin
        bus_we_o   = 1'b1;
        bus_adr_o  = ADDR_CTRL;
        bus_wdat_o = 32'd0;
        case (state)
            LOOP_WRITE_SCALE: begin
                bus_adr_o  = ADDR_SCALE;
                bus_wdat_o = {15'd0, cur_scale_o};
            end
            LOOP_WRITE_OFFSET: begin
                bus_adr_o  = ADDR_OFFSET;
                bus_wdat_o = {{16{cur_offset_o[15]}}, cur_offset_o};
            end
            LOOP_LOAD:  bus_wdat_o = CMD_LOAD;
            LOOP_APPLY: bus_wdat_o = CMD_APPLY;
            LOOP_RESET: bus_wdat_o = CMD_RESET;
            LOOP_START: bus_wdat_o = CMD_START;
            LOOP_POLL:  bus_we_o   = 1'b0;   // Status word
            LOOP_READ: begin
                bus_we_o  = 1'b0;
                bus_adr_o = {3'd0, info_idx, 2'b00};
            end
            default: bus_we_o = 1'b0;
        endcase
    end

endmodule

// File: agc_loop_top.sv
`timescale 1ns/1ps

module agc_loop_top
    import agc_loop_pkg::*;
(
    input  logic        aclk,
    input  logic        wb_rst_i,
    input  logic        agc_reset_i,
    // Host side
    input  logic        host_cyc_i,
    input  logic        host_stb_i,
    input  logic        host_we_i,
    input  logic [7:0]  host_adr_i,
    input  logic [31:0] host_dat_i,
    output logic        host_ack_o,
    output logic [31:0] host_dat_o,
    // Downstream AGC
    output logic        agc_cyc_o,
    output logic        agc_stb_o,
    output logic        agc_we_o,
    output logic [7:0]  agc_adr_o,
    output logic [31:0] agc_dat_o,
    output logic [3:0]  agc_sel_o,
    input  logic        agc_ack_i,
    input  logic [31:0] agc_dat_i,
    output logic        agc_chan_mask_o
);

    logic        bus_req;
    logic        bus_we;
    logic [7:0]  bus_adr;
    logic [31:0] bus_wdat;
    logic        bus_done;
    logic [31:0] bus_rdat;
    logic [16:0] scale_delta;
    logic [15:0] offset_delta;
    logic [16:0] cur_scale;
    logic [15:0] cur_offset;
    logic [16:0] next_scale;
    logic [15:0] next_offset;
    agc_info_t   agc_info;

    agc_host_regs i_host_regs (
        .aclk(aclk), .wb_rst_i(wb_rst_i),
        .host_cyc_i(host_cyc_i), .host_stb_i(host_stb_i), .host_we_i(host_we_i),
        .host_adr_i(host_adr_i), .host_dat_i(host_dat_i), .agc_info_i(agc_info),
        .host_ack_o(host_ack_o), .host_dat_o(host_dat_o),
        .scale_delta_o(scale_delta), .offset_delta_o(offset_delta),
        .chan_mask_o(agc_chan_mask_o)
    );

    agc_bus_master i_bus_master (
        .aclk(aclk), .wb_rst_i(wb_rst_i),
        .req_i(bus_req), .we_i(bus_we), .adr_i(bus_adr), .wdat_i(bus_wdat),
        .done_o(bus_done), .rdat_o(bus_rdat),
        .agc_cyc_o(agc_cyc_o), .agc_stb_o(agc_stb_o), .agc_we_o(agc_we_o),
        .agc_adr_o(agc_adr_o), .agc_dat_o(agc_dat_o), .agc_sel_o(agc_sel_o),
        .agc_ack_i(agc_ack_i), .agc_dat_i(agc_dat_i)
    );

    agc_update_calc i_update_calc (
        .agc_info_i(agc_info), .scale_delta_i(scale_delta),
        .offset_delta_i(offset_delta), .prev_scale_i(cur_scale),
        .prev_offset_i(cur_offset), .next_scale_o(next_scale),
        .next_offset_o(next_offset)
    );

    agc_loop_fsm i_loop_fsm (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .agc_reset_i(agc_reset_i),
        .bus_done_i(bus_done), .bus_rdat_i(bus_rdat),
        .bus_req_o(bus_req), .bus_we_o(bus_we), .bus_adr_o(bus_adr),
        .bus_wdat_o(bus_wdat), .chan_mask_i(agc_chan_mask_o),
        .next_scale_i(next_scale), .next_offset_i(next_offset),
        .cur_scale_o(cur_scale), .cur_offset_o(cur_offset), .agc_info_o(agc_info)
    );

endmodule

// File: agc_loop_sva.sv
`timescale 1ns/1ps

module agc_loop_sva (
    input logic        aclk,
    input logic        wb_rst_i,
    input logic        agc_cyc_o,
    input logic        agc_stb_o,
    input logic        agc_we_o,
    input logic [7:0]  agc_adr_o,
    input logic [31:0] agc_dat_o,
    input logic [3:0]  agc_sel_o,
    input logic        agc_ack_i,
    input logic        host_cyc_i,
    input logic        host_stb_i,
    input logic        host_ack_o
);

    int sva_errors = 0;

    ////////////////////////////////////////
    // Downstream bus
    ////////////////////////////////////////
    a_hold: assert property (@(posedge aclk) disable iff (wb_rst_i)
        (agc_cyc_o && !agc_ack_i) |=>
            agc_cyc_o && agc_stb_o && $stable({agc_we_o, agc_adr_o, agc_dat_o, agc_sel_o}))
        else begin
            sva_errors++;
            $error("downstream outputs changed before the acknowledge");
        end

    a_drop: assert property (@(posedge aclk) disable iff (wb_rst_i)
        (agc_cyc_o && agc_ack_i) |=> !agc_cyc_o)
        else begin
            sva_errors++;
            $error("cycle still high after the acknowledge");
        end

    // Host side
    a_ack_len: assert property (@(posedge aclk) disable iff (wb_rst_i)
        host_ack_o |=> !host_ack_o)
        else begin
            sva_errors++;
            $error("host acknowledge longer than one cycle");
        end

    a_ack_lat: assert property (@(posedge aclk) disable iff (wb_rst_i)
        $rose(host_cyc_i && host_stb_i) |-> ##2 host_ack_o)
        else begin
            sva_errors++;
            $error("host acknowledge not two cycles after the request");
        end

endmodule

bind agc_loop_top agc_loop_sva i_sva (
    .aclk(aclk), .wb_rst_i(wb_rst_i),
    .agc_cyc_o(agc_cyc_o), .agc_stb_o(agc_stb_o), .agc_we_o(agc_we_o),
    .agc_adr_o(agc_adr_o), .agc_dat_o(agc_dat_o), .agc_sel_o(agc_sel_o),
    .agc_ack_i(agc_ack_i), .host_cyc_i(host_cyc_i), .host_stb_i(host_stb_i),
    .host_ack_o(host_ack_o)
);

// File: agc_loop_checker.sv
`timescale 1ns/1ps

module agc_loop_checker
    import agc_loop_pkg::*;
(
    input  logic        aclk,
    input  logic        wb_rst_i,
    input  logic        agc_reset_i,
    input  logic        agc_cyc_i,
    input  logic        agc_stb_i,
    input  logic        agc_we_i,
    input  logic [7:0]  agc_adr_i,
    input  logic [31:0] agc_wdat_i,
    input  logic [3:0]  agc_sel_i,
    input  logic        agc_ack_i,
    input  logic        host_ack_i,
    input  logic [31:0] host_dat_i,
    input  logic        chan_mask_i,
    input  logic        host_chk_i,
    input  logic [31:0] host_exp_i,
    input  logic [31:0] exp_scale_i,
    input  logic [31:0] exp_offset_i,
    input  logic        exp_mask_i,
    input  int          exp_polls_i,
    input  logic [95:0] name_i,
    output int          tests_o,
    output int          checks_o,
    output int          errors_o
);

    int   phase;   // 0 writes, 1 status polls, 2 information reads
    int   idx;
    int   polls;
    int   row_err;
    logic skip_reads;   // A read may still finish after a loop reset
    logic [7:0]  exp_adr;
    logic [31:0] exp_dat;

    initial begin
        tests_o    = 0;
        checks_o   = 0;
        errors_o   = 0;
        phase      = 0;
        idx        = 0;
        polls      = 0;
        row_err    = 0;
        skip_reads = 0;
    end

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks_o++;
        if (exp !== act) begin
            errors_o++;
            row_err++;
            $display("mismatch %0s %0s: expected %h, actual %h", name_i, what, exp, act);
        end
    endtask

    task automatic fail(input string why);
        errors_o++;
        row_err++;
        $display("error in %0s: %0s", name_i, why);
    endtask

    // Write sequence of one update in command order
    always_comb begin
        exp_adr = ADDR_CTRL;
        exp_dat = CMD_START;
        case (idx)
            0: begin
                exp_adr = ADDR_SCALE;
                exp_dat = exp_scale_i;
            end
            1: begin
                exp_adr = ADDR_OFFSET;
                exp_dat = exp_offset_i;
            end
            2: exp_dat = CMD_LOAD;
            3: exp_dat = CMD_APPLY;
            4: exp_dat = CMD_RESET;
            default: ;
        endcase
    end

    always @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            phase = 0;
            idx = 0;
            polls = 0;
            row_err = 0;
            skip_reads = agc_reset_i;
        end else if (agc_cyc_i && agc_stb_i && agc_ack_i) begin
            compare("byte select", 32'hF, {28'd0, agc_sel_i});
            if (agc_we_i) begin
                if (phase != 0)
                    fail("write arrived while reads were expected");
                compare("write address", {24'd0, exp_adr}, {24'd0, agc_adr_i});
                compare("write data", exp_dat, agc_wdat_i);
                skip_reads = 0;
                phase = 0;
                idx++;
                if (idx == 6) begin   // Start command closes the test
                    compare("channel mask", {31'd0, exp_mask_i}, {31'd0, chan_mask_i});
                    $display("test %0s: %0s", name_i, (row_err == 0) ? "ok" : "failed");
                    tests_o++;
                    row_err = 0;
                    phase = 1;
                    idx = 0;
                    polls = 0;
                end
            end else if (phase == 1 && agc_adr_i == ADDR_CTRL) begin
                polls++;   // Status polls and information word 0 share address 0
            end else if (phase != 0) begin
                if (phase == 1) begin
                    // Polls before done, the done read and word 0
                    compare("poll count", 32'(exp_polls_i + 2), 32'(polls));
                    phase = 2;
                    idx = 1;
                end
                compare("read address", 32'(idx * 4), {24'd0, agc_adr_i});
                idx++;
                if (idx == INFO_WORDS) begin
                    phase = 0;
                    idx = 0;
                end
            end else if (!skip_reads) begin
                fail("downstream read arrived during the write sequence");
            end
        end
        if (!wb_rst_i && host_ack_i && host_chk_i)
            compare("host read", host_exp_i, host_dat_i);
    end

endmodule

// File: tb_agc_loop.sv
`timescale 1ns/1ps

module tb_agc_loop
    import agc_loop_pkg::*;
();

    localparam int NUM_ROWS  = 5;
    localparam int NUM_TESTS = NUM_ROWS + 2;   // Boot and agc reset sequences too
    localparam int CYC_LIMIT = NUM_TESTS * 120 + BOOT_DELAY;

    logic        aclk;
    logic        wb_rst_i;
    logic        agc_reset_i;
    logic        host_cyc_i;
    logic        host_stb_i;
    logic        host_we_i;
    logic [7:0]  host_adr_i;
    logic [31:0] host_dat_i;
    logic        host_ack_o;
    logic [31:0] host_dat_o;
    logic        agc_cyc_o;
    logic        agc_stb_o;
    logic        agc_we_o;
    logic [7:0]  agc_adr_o;
    logic [31:0] agc_dat_o;
    logic [3:0]  agc_sel_o;
    logic        agc_ack_i;
    logic [31:0] agc_dat_i;
    logic        agc_chan_mask_o;

    // Expectations handed to the checker
    logic        host_chk;
    logic [31:0] host_exp;
    logic [31:0] exp_scale;
    logic [31:0] exp_offset;
    logic        exp_mask;
    int          exp_polls;
    logic [95:0] test_name;
    int          tests;
    int          checks;
    int          errors;

    // Stimulus table with one row per loop iteration
    logic [95:0] tab_name   [NUM_ROWS];
    int          tab_polls  [NUM_ROWS];
    logic [31:0] tab_info   [NUM_ROWS][6];
    logic [16:0] tab_sdelta [NUM_ROWS];
    logic [15:0] tab_odelta [NUM_ROWS];
    logic        tab_mask   [NUM_ROWS];
    logic [31:0] tab_scale  [NUM_ROWS];
    logic [31:0] tab_offset [NUM_ROWS];

    // AGC model state
    int          row_ptr;
    int          start_cnt;
    int          polls_left;
    logic        in_poll;
    logic        busy;
    logic [1:0]  dly;
    logic [31:0] lfsr;
    logic        bit0;
    logic        bit1;
    int          cycles;

    logic [31:0] prev_scale;
    logic [31:0] prev_offset;
    logic        applied_mask;

    agc_loop_top i_dut (.*);

    agc_loop_checker i_checker (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .agc_reset_i(agc_reset_i),
        .agc_cyc_i(agc_cyc_o), .agc_stb_i(agc_stb_o), .agc_we_i(agc_we_o),
        .agc_adr_i(agc_adr_o), .agc_wdat_i(agc_dat_o), .agc_sel_i(agc_sel_o),
        .agc_ack_i(agc_ack_i), .host_ack_i(host_ack_o), .host_dat_i(host_dat_o),
        .chan_mask_i(agc_chan_mask_o), .host_chk_i(host_chk), .host_exp_i(host_exp),
        .exp_scale_i(exp_scale), .exp_offset_i(exp_offset), .exp_mask_i(exp_mask),
        .exp_polls_i(exp_polls), .name_i(test_name),
        .tests_o(tests), .checks_o(checks), .errors_o(errors)
    );

    always #10 aclk = ~aclk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic set_row(input int r, input logic [95:0] name, input int polls,
                           input logic [31:0] sumsq, input logic [31:0] above,
                           input logic [31:0] below, input logic [31:0] scale,
                           input logic [31:0] offset, input logic [16:0] sdelta,
                           input logic [15:0] odelta, input logic mask,
                           input logic [31:0] e_scale, input logic [31:0] e_offset);
        tab_name[r]    = name;
        tab_polls[r]   = polls;
        tab_info[r][0] = 32'h2;   // Done status
        tab_info[r][1] = sumsq;
        tab_info[r][2] = above;
        tab_info[r][3] = below;
        tab_info[r][4] = scale;
        tab_info[r][5] = offset;
        tab_sdelta[r]  = sdelta;
        tab_odelta[r]  = odelta;
        tab_mask[r]    = mask;
        tab_scale[r]   = e_scale;
        tab_offset[r]  = e_offset;
    endtask

    // One host access held until the acknowledge shows
    task automatic host_access(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                               input logic chk, input logic [31:0] exp);
        @(posedge aclk);
        #1;
        host_cyc_i = 1'b1;
        host_stb_i = 1'b1;
        host_we_i  = we;
        host_adr_i = adr;
        host_dat_i = dat;
        host_chk   = chk;
        host_exp   = exp;
        @(posedge aclk);
        #1;
        while (!host_ack_o) begin
            @(posedge aclk);
            #1;
        end
        host_cyc_i = 1'b0;
        host_stb_i = 1'b0;
        host_we_i  = 1'b0;
    endtask

    ////////////////////////////////////////
    // Downstream AGC model
    ////////////////////////////////////////
    always @(posedge aclk) begin
        #1;
        if (wb_rst_i || agc_ack_i) begin   // Ack was sampled at this edge
            agc_ack_i = 1'b0;
            busy      = 1'b0;
        end else if (agc_cyc_o && agc_stb_o) begin
            if (!busy) begin
                busy = 1'b1;
                bit0 = lfsr[0];
                lfsr = lfsr_next(lfsr);
                bit1 = lfsr[0];
                lfsr = lfsr_next(lfsr);
                dly  = {bit1, bit0};
            end
            if (dly != 2'd0) begin
                dly = dly - 2'd1;
            end else begin
                agc_ack_i = 1'b1;
                if (agc_we_o) begin
                    if (agc_adr_o == ADDR_CTRL && agc_dat_o == CMD_START) begin
                        start_cnt++;
                        in_poll    = 1'b1;
                        polls_left = (row_ptr < NUM_ROWS) ? tab_polls[row_ptr] : 0;
                        exp_polls  = polls_left;
                    end
                end else if (row_ptr >= NUM_ROWS) begin
                    agc_dat_i = 32'd0;   // Past the table the sample never finishes
                end else if (in_poll) begin
                    if (polls_left > 0) begin
                        polls_left--;
                        agc_dat_i = 32'd0;
                    end else begin
                        agc_dat_i = 32'd1 << STATUS_DONE_BIT;
                        in_poll   = 1'b0;
                    end
                end else begin
                    agc_dat_i = tab_info[row_ptr][agc_adr_o[4:2]];
                    if (agc_adr_o[4:2] == 3'd5) begin   // Next writes carry the result
                        exp_scale  = tab_scale[row_ptr];
                        exp_offset = tab_offset[row_ptr];
                        test_name  = tab_name[row_ptr];
                        row_ptr++;
                    end
                end
            end
        end
    end

    // Run limit
    always @(posedge aclk) begin
        if (!wb_rst_i) begin
            cycles++;
            if (cycles > CYC_LIMIT) begin
                $display("timeout: the loop made no progress within %0d cycles", CYC_LIMIT);
                $display("Done: errors found");
                $finish;
            end
        end
    end

    initial begin
        aclk        = 0;
        wb_rst_i    = 1;
        agc_reset_i = 0;
        host_cyc_i  = 0;
        host_stb_i  = 0;
        host_we_i   = 0;
        host_adr_i  = 0;
        host_dat_i  = 0;
        agc_ack_i   = 0;
        agc_dat_i   = 0;
        host_chk    = 0;
        host_exp    = 0;
        exp_mask    = 0;
        exp_polls   = 0;
        exp_scale   = {15'd0, START_SCALE};
        exp_offset  = {{16{START_OFFSET[15]}}, START_OFFSET};
        test_name   = "boot";
        row_ptr     = 0;
        start_cnt   = 0;
        polls_left  = 0;
        in_poll     = 0;
        busy        = 0;
        dly         = 0;
        lfsr        = 32'h222c41f5;
        cycles      = 0;
        prev_scale   = exp_scale;
        prev_offset  = exp_offset;
        applied_mask = 0;

        //      row name         polls sumsq      above below scale    offset
        set_row(0, "above_band", 2, 32'h28000, 50,  10, 1000,    32'd0,
                30, 25, 1'b1, 32'd970, 32'hFFFF_FFE7);
        set_row(1, "below_band", 3, 32'h10000, 10,  30, 2000,    32'd100,
                40, 10, 1'b0, 32'd2040, 32'd110);
        set_row(2, "in_band",    1, 32'h20000, 12,  10, 500,     32'd7,
                40, 10, 1'b0, 32'd2040, 32'd110);
        set_row(3, "scale_min",  4, 32'h28000, 100, 0,  300,     32'd5,
                50, 10, 1'b1, 32'd300, 32'hFFFF_FFFB);
        set_row(4, "scale_max",  2, 32'h10000, 0,   40, 130000,  32'hFFFF_FFEC,
                50, 10, 1'b1, 32'd130000, 32'hFFFF_FFF6);

        repeat (16) @(posedge aclk);
        #1 wb_rst_i = 0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            wait (start_cnt == r + 1);   // Polling of row r has begun
            host_access(1'b0, 8'h10, 32'd0, 1'b1, prev_scale);
            host_access(1'b0, 8'h14, 32'd0, 1'b1, prev_offset);
            host_access(1'b0, HOST_MASK_ADDR, 32'd0, 1'b1, {31'd0, applied_mask});
            host_access(1'b1, HOST_SDELTA_ADDR, {15'd0, tab_sdelta[r]}, 1'b0, 32'd0);
            host_access(1'b1, HOST_ODELTA_ADDR, {16'd0, tab_odelta[r]}, 1'b0, 32'd0);
            host_access(1'b1, HOST_MASK_ADDR, {31'd0, tab_mask[r]}, 1'b0, 32'd0);
            exp_mask = tab_mask[r];
            host_access(1'b0, HOST_SDELTA_ADDR, 32'd0, 1'b1, {15'd0, tab_sdelta[r]});
            host_access(1'b0, HOST_ODELTA_ADDR, 32'd0, 1'b1,
                        {{16{tab_odelta[r][15]}}, tab_odelta[r]});
            prev_scale   = tab_scale[r];
            prev_offset  = tab_offset[r];
            applied_mask = tab_mask[r];
        end

        // Loop reset brings back the starting sequence
        wait (tests == NUM_ROWS + 1);
        exp_scale  = {15'd0, START_SCALE};
        exp_offset = {{16{START_OFFSET[15]}}, START_OFFSET};
        test_name  = "agc_reset";
        @(posedge aclk);
        #1 agc_reset_i = 1;
        @(posedge aclk);
        #1 agc_reset_i = 0;
        wait (tests == NUM_TESTS);
        @(posedge aclk);

        $display("tests %0d, checks %0d, errors %0d", tests, checks,
                 errors + i_dut.i_sva.sva_errors);
        if (errors + i_dut.i_sva.sva_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: flist.f
agc_loop_pkg.sv
agc_host_regs.sv
agc_bus_master.sv
agc_update_calc.sv
agc_loop_fsm.sv
agc_loop_top.sv
agc_loop_sva.sv
agc_loop_checker.sv
tb_agc_loop.sv

// File: Bender.yml
package:
  name: agc_loop

sources:
  - agc_loop_pkg.sv
  - agc_host_regs.sv
  - agc_bus_master.sv
  - agc_update_calc.sv
  - agc_loop_fsm.sv
  - agc_loop_top.sv
  - target: test
    files:
      - agc_loop_sva.sv
      - agc_loop_checker.sv
      - tb_agc_loop.sv
